// File: sobel_testdata.txt
// Columns (hex): rows cols stall_flag lane_pixel_total go_cycle_count
// A line of zeros ends the list.
4 4 0 4 7
5 7 0 f 19
6 8 1 18 1f
7 9 1 23 31
4 5 1 6 d
a c 0 50 5b
8 6 1 18 1d
0 0 0 0 0

// File: vlog.f
sobel_ctl_pkg.sv
sobel_ctl_fsm.sv
sobel_scan_counter.sv
sobel_buf_addr_gen.sv
sobel_control.sv
sobel_control_chk.sv
sobel_control_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= sobel_control_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulator output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sobel_control_tb.sv
//////////////////////////////////////////////////
// Testbench for the Sobel control unit. It replays the
// image cases from the test data and checks every output.
//////////////////////////////////////////////////
`default_nettype none

module sobel_control_tb;
    import sobel_ctl_pkg::*;

    localparam int n_lanes   = 2;
    localparam int max_cases = 16;

    logic                  clk;
    logic                  reset;
    logic                  go;
    image_dim_t            image_dim;
    logic [ADDR_WIDTH-1:0] read_addr;
    logic [ADDR_WIDTH-1:0] write_addr;
    logic [n_lanes-1:0]    write_en;
    row_op_e               row_op;
    ctl_status_t           status;

    // Five words per case: rows, cols, stall flag, pixel total, go-cycle count.
    logic [31:0] test_mem [0:max_cases*5-1];

    logic [31:0] rng_state;
    int          cycle_count;
    int          cycle_limit;

    // Expected write and read sequences of the case being run.
    logic [ADDR_WIDTH-1:0] exp_waddr [$];
    logic [n_lanes-1:0]    exp_wmask [$];
    logic [ADDR_WIDTH-1:0] exp_raddr [$];

    sobel_control #(
        .n_lanes (n_lanes)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .image_dim  (image_dim),
        .read_addr  (read_addr),
        .write_addr (write_addr),
        .write_en   (write_en),
        .row_op     (row_op),
        .status     (status)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // The run is cut off once the cycle budget of all cases is used up.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the cases did not finish within %0d cycles.", cycle_limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation stopped by the cycle limit.");
        end
    end

    // Xorshift step for the stall pattern.
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_value(input string what);
        $display("[FAIL] t=%0t %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first mismatch.");
    endtask

    // Builds the address sequences from the strip walk.
    // Strip s writes output row r at r*(cols-2)+s and reads s+k*cols.
    task automatic build_expectations(input int rows, input int cols, input int case_no,
                                      input int exp_pixels, input int exp_cycles);
        int out_w;
        int lanes;
        int pixels;
        int strips;
        out_w  = cols - 2;
        pixels = 0;
        strips = 0;
        exp_waddr.delete();
        exp_wmask.delete();
        exp_raddr.delete();
        for (int s = 0; s < out_w; s += n_lanes) begin
            lanes = (out_w - s < n_lanes) ? out_w - s : n_lanes;
            strips++;
            for (int k = 0; k < rows; k++) begin
                exp_raddr.push_back(ADDR_WIDTH'(s + k * cols));
            end
            for (int r = 0; r < rows - 2; r++) begin
                exp_waddr.push_back(ADDR_WIDTH'(r * out_w + s));
                exp_wmask.push_back(n_lanes'((1 << lanes) - 1));
                pixels += lanes;
            end
        end
        assert (pixels == exp_pixels && 1 + strips * (2 * rows - 2) == exp_cycles)
            else fail_value($sformatf("test data line %0d disagrees with its image size",
                                      case_no));
    endtask

    task automatic run_case(input int case_no, input int rows, input int cols,
                            input logic stall, input int exp_pixels, input int exp_cycles);
        int                    pixels;
        int                    go_cycles;
        logic                  done_seen;
        logic [ADDR_WIDTH-1:0] prev_read;
        logic [ADDR_WIDTH-1:0] want_addr;
        logic [n_lanes-1:0]    want_mask;
        pixels    = 0;
        go_cycles = 0;
        done_seen = 1'b0;
        prev_read = '0;
        build_expectations(rows, cols, case_no, exp_pixels, exp_cycles);
        @(posedge clk);
        image_dim.n_rows <= DIM_WIDTH'(rows);
        image_dim.n_cols <= DIM_WIDTH'(cols);
        go               <= 1'b1;
        while (!done_seen) begin
            @(negedge clk);
            assert (go || write_en == '0)
                else fail_value($sformatf("write_en %b while go is low", write_en));
            assert (!status.error) else fail_value("error flag raised during a run");
            if (status.done) begin
                done_seen = 1'b1;
            end else begin
                if (go) begin
                    go_cycles++;
                    if (row_op == row_op_shift_row) begin
                        assert (exp_raddr.size() > 0) else fail_value("extra row shift");
                        want_addr = exp_raddr.pop_front();
                        assert (prev_read == want_addr)
                            else fail_value($sformatf("shift read addr %0d, expected %0d",
                                                      prev_read, want_addr));
                    end
                    if (write_en != '0) begin
                        assert (exp_waddr.size() > 0) else fail_value("extra write");
                        want_addr = exp_waddr.pop_front();
                        want_mask = exp_wmask.pop_front();
                        assert (write_addr == want_addr && write_en == want_mask)
                            else fail_value($sformatf("write addr %0d en %b, expected %0d en %b",
                                                      write_addr, write_en, want_addr, want_mask));
                        pixels += $countones(write_en);
                    end
                    prev_read = read_addr;
                end
                @(posedge clk);
                rng_state = next_random(rng_state);
                // Single-cycle stalls, never on the cycle that would end the run.
                if (stall && go && go_cycles < exp_cycles && rng_state[2:0] == 3'd0) begin
                    go <= 1'b0;
                end else begin
                    go <= 1'b1;
                end
            end
        end
        assert (go_cycles == exp_cycles)
            else fail_value($sformatf("done after %0d go cycles, expected %0d",
                                      go_cycles, exp_cycles));
        assert (pixels == exp_pixels && exp_waddr.size() == 0 && exp_raddr.size() == 0)
            else fail_value($sformatf("%0d lane pixels written, expected %0d",
                                      pixels, exp_pixels));
        // Done stays up for the go-low cycle, then the FSM is back in wait.
        @(posedge clk);
        go <= 1'b0;
        @(negedge clk);
        assert (status.done) else fail_value("done dropped before go was released");
        @(negedge clk);
        assert (status.state == st_wait && !status.done && write_en == '0 && read_addr == '0)
            else fail_value("controller did not return to wait after done");
    endtask

    initial begin
        int n_cases;
        rng_state   = 32'h8911_cc0e;
        cycle_count = 0;
        cycle_limit = 100;
        reset       = 1'b1;
        go          = 1'b0;
        image_dim   = '0;
        $readmemh("sobel_testdata.txt", test_mem);
        n_cases = 0;
        while (n_cases < max_cases && test_mem[n_cases*5] != 0) begin
            cycle_limit += 2 * int'(test_mem[n_cases*5+4]);
            n_cases++;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (write_en == '0 && row_op == row_op_hold && !status.done && !status.error
                && status.state == st_wait && read_addr == '0 && write_addr == '0)
            else fail_value("outputs after reset are not at their idle values");
        for (int i = 0; i < n_cases; i++) begin
            run_case(i, int'(test_mem[i*5]), int'(test_mem[i*5+1]), test_mem[i*5+2][0],
                     int'(test_mem[i*5+3]), int'(test_mem[i*5+4]));
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sobel_control_chk.sv
//////////////////////////////////////////////////
// Bound assertions on the step strobes, the row
// command and the write enables.
//////////////////////////////////////////////////
`default_nettype none

module sobel_control_chk
    import sobel_ctl_pkg::*;
#(
    parameter int n_lanes = 2
) (
    input wire logic               clk,
    input wire logic               reset,
    input wire logic               go,
    input wire ctl_step_t          step,
    input wire row_op_e            row_op,
    input wire ctl_status_t        status,
    input wire logic [n_lanes-1:0] write_en
);

    logic load_state;

    assign load_state = (status.state == st_load_1) || (status.state == st_load_2)
                        || (status.state == st_load_3) || (status.state == st_load_next)
                        || (status.state == st_load_last);

    // Start rides on idle and strip_start on row_advance.
    // The remaining strobes name one state each.
    step_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({step.first_load, step.hold_read, step.row_advance, step.out_row,
                  step.strip_end, step.idle, step.clear})
        && (!step.start || step.idle) && (!step.strip_start || step.row_advance))
        else $error("step strobes overlap");

    // The row registers shift on load states and only there.
    shift_on_load: assert property (@(posedge clk) disable iff (reset)
        (row_op == row_op_shift_row) == load_state)
        else $error("row_op does not follow the load states");

    stall_no_write: assert property (@(posedge clk) disable iff (reset)
        !go |-> (write_en == '0))
        else $error("write enable high during a stall");

endmodule

bind sobel_control sobel_control_chk #(
    .n_lanes (n_lanes)
) chk0 (
    .clk      (clk),
    .reset    (reset),
    .go       (go),
    .step     (step),
    .row_op   (row_op),
    .status   (status),
    .write_en (write_en)
);

`default_nettype wire

// File: sobel_control.sv
//////////////////////////////////////////////////
// Top level of the Sobel control unit.
//////////////////////////////////////////////////
`default_nettype none

module sobel_control
    import sobel_ctl_pkg::*;
#(
    parameter int n_lanes = 2
) (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             go,
    input  wire image_dim_t       image_dim,
    output logic [ADDR_WIDTH-1:0] read_addr,
    output logic [ADDR_WIDTH-1:0] write_addr,
    output logic [n_lanes-1:0]    write_en,
    output row_op_e               row_op,
    output ctl_status_t           status
);

    ctl_step_t          step;
    strip_info_t        strip;
    image_dim_t         dim;
    logic [n_lanes-1:0] lane_mask;

    // State machine, which owns the row command and the status.
    sobel_ctl_fsm fsm0 (
        .clk    (clk),
        .reset  (reset),
        .go     (go),
        .strip  (strip),
        .step   (step),
        .row_op (row_op),
        .status (status)
    );

    // Size latch, row and strip counters, lane mask.
    sobel_scan_counter #(
        .n_lanes (n_lanes)
    ) scan0 (
        .clk          (clk),
        .reset        (reset),
        .go           (go),
        .step         (step),
        .image_dim_in (image_dim),
        .dim          (dim),
        .strip        (strip),
        .lane_mask    (lane_mask)
    );

    // Buffer offsets and write enables.
    sobel_buf_addr_gen #(
        .n_lanes (n_lanes)
    ) addr0 (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .step       (step),
        .dim        (dim),
        .strip      (strip),
        .lane_mask  (lane_mask),
        .read_addr  (read_addr),
        .write_addr (write_addr),
        .write_en   (write_en)
    );

endmodule

`default_nettype wire

// File: sobel_buf_addr_gen.sv
//////////////////////////////////////////////////
// Input read offset, output write offset and per-lane write enables.
//////////////////////////////////////////////////
`default_nettype none

module sobel_buf_addr_gen
    import sobel_ctl_pkg::*;
#(
    parameter int n_lanes = 2
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               go,
    input  wire ctl_step_t          step,
    input  wire image_dim_t         dim,
    input  wire strip_info_t        strip,
    input  wire logic [n_lanes-1:0] lane_mask,
    output logic [ADDR_WIDTH-1:0]   read_addr,
    output logic [ADDR_WIDTH-1:0]   write_addr,
    output logic [n_lanes-1:0]      write_en
);

    logic [ADDR_WIDTH-1:0] read_offset;
    logic [ADDR_WIDTH-1:0] write_offset;
    logic [ADDR_WIDTH-1:0] row_stride;
    logic [ADDR_WIDTH-1:0] out_stride;
    logic [ADDR_WIDTH-1:0] strip_base;
    logic                  offset_en;

    // Strides and the next strip start, widened to buffer offsets.
    assign row_stride = ADDR_WIDTH'(dim.n_cols);
    assign out_stride = ADDR_WIDTH'(dim.n_cols - DIM_WIDTH'(2));
    assign strip_base = ADDR_WIDTH'(strip.next_strip);

    // Offsets move with go, and are also parked at zero while idle.
    assign offset_en = go || step.idle;

    // Read offset.
    // The row registers take the data of the address presented one cycle
    // earlier, so the offset always runs one row ahead of the shift.
    always_ff @(posedge clk) begin
        if (reset) begin
            read_offset <= '0;
        end else if (offset_en) begin
            if (step.start) begin
                read_offset <= row_stride;
            end else if (step.idle || step.clear) begin
                read_offset <= '0;
            end else if (step.strip_start) begin
                // The final load of a strip points at the top of the next one.
                read_offset <= strip_base;
            end else if (!(step.hold_read || step.out_row)) begin
                // Load_1, load_3, load_next and calc_last each step one row.
                // Calc_last plays the part of the start cycle for a new strip.
                read_offset <= read_offset + row_stride;
            end
        end
    end

    // Write offset walks down the output column, one output row per calc.
    always_ff @(posedge clk) begin
        if (reset) begin
            write_offset <= '0;
        end else if (offset_en) begin
            if (step.idle) begin
                write_offset <= '0;
            end else if (step.out_row) begin
                write_offset <= write_offset + out_stride;
            end else if (step.strip_end && !strip.last_strip) begin
                write_offset <= strip_base;
            end
        end
    end

    assign read_addr  = read_offset;
    assign write_addr = write_offset;

    // Lanes write on both calc states, never during a stall.
    assign write_en = (go && (step.out_row || step.strip_end)) ? lane_mask : '0;

endmodule

`default_nettype wire

// File: sobel_scan_counter.sv
//////////////////////////////////////////////////
// Image size latch, row counter, column-strip counter
// and the lane mask for a narrow last strip.
//////////////////////////////////////////////////
`default_nettype none

module sobel_scan_counter
    import sobel_ctl_pkg::*;
#(
    parameter int n_lanes = 2
) (
    input  wire logic         clk,
    input  wire logic         reset,
    input  wire logic         go,
    input  wire ctl_step_t    step,
    input  wire image_dim_t   image_dim_in,
    output image_dim_t        dim,
    output strip_info_t       strip,
    output logic [n_lanes-1:0] lane_mask
);

    localparam logic [DIM_WIDTH-1:0] lane_step = DIM_WIDTH'(n_lanes);

    image_dim_t           dim_q;
    logic [DIM_WIDTH-1:0] row_count;
    logic [DIM_WIDTH-1:0] col_strip;
    logic [DIM_WIDTH-1:0] out_width;
    logic [DIM_WIDTH-1:0] lane_rem;
    logic [DIM_WIDTH-1:0] max_strip;

    // The size is captured on every idle cycle, with or without go.
    always_ff @(posedge clk) begin
        if (step.idle) begin
            dim_q <= image_dim_in;
        end
    end

    // While idle the live size passes through, so the start cycle
    // already works with the new image.
    assign dim = step.idle ? image_dim_in : dim_q;

    // Row counter. It counts the rows shifted in after the first three.
    always_ff @(posedge clk) begin
        if (reset) begin
            row_count <= '0;
        end else if (go) begin
            if (step.clear) begin
                row_count <= '0;
            end else if (step.idle || step.strip_end) begin
                row_count <= DIM_WIDTH'(1);
            end else if (step.row_advance) begin
                row_count <= row_count + DIM_WIDTH'(1);
            end
        end
    end

    // Start column of the current strip.
    always_ff @(posedge clk) begin
        if (reset) begin
            col_strip <= '0;
        end else if (go) begin
            if (step.idle || step.clear) begin
                col_strip <= '0;
            end else if (step.strip_end) begin
                col_strip <= strip.next_strip;
            end
        end
    end

    // The output image is two pixels narrower than the input.
    // The last strip starts n_lanes before its end, or at the partial remainder.
    assign out_width = dim.n_cols - DIM_WIDTH'(2);
    assign lane_rem  = out_width % lane_step;
    assign max_strip = (lane_rem == '0) ? (out_width - lane_step) : (out_width - lane_rem);

    always_comb begin
        strip.col_strip  = col_strip;
        strip.next_strip = col_strip + lane_step;
        strip.last_row   = (row_count == (dim.n_rows - DIM_WIDTH'(3)));
        strip.last_strip = (col_strip == max_strip);
    end

    // Only the lowest lanes of a partial last strip carry real pixels.
    always_comb begin
        for (int i = 0; i < n_lanes; i++) begin
            lane_mask[i] = (lane_rem == '0) || !strip.last_strip
                           || (DIM_WIDTH'(i) < lane_rem);
        end
    end

endmodule

`default_nettype wire

// File: sobel_ctl_fsm.sv
//////////////////////////////////////////////////
// Strip-walking state machine with row command, step strobes
// and status decode.
//////////////////////////////////////////////////
`default_nettype none

module sobel_ctl_fsm
    import sobel_ctl_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        go,
    input  wire strip_info_t strip,
    output ctl_step_t        step,
    output row_op_e          row_op,
    output ctl_status_t      status
);

    ctl_state_e state;
    ctl_state_e state_next;

    // The state register itself is always loaded.
    // Stalls come from the go terms in the next-state logic.
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_wait;
        end else begin
            state <= state_next;
        end
    end

    // Next state. Every transition except the exit from done needs go,
    // so a low go freezes the walk in place.
    always_comb begin
        state_next = state;
        case (state)
            st_wait: begin
                if (go) begin
                    state_next = st_load_1;
                end
            end
            st_load_1: begin
                if (go) begin
                    state_next = st_load_2;
                end
            end
            st_load_2: begin
                if (go) begin
                    state_next = st_load_3;
                end
            end
            st_load_3: begin
                if (go) begin
                    state_next = st_calc;
                end
            end
            st_calc: begin
                // The output row before the last one leads into the final load.
                if (go) begin
                    state_next = strip.last_row ? st_load_last : st_load_next;
                end
            end
            st_load_next: begin
                if (go) begin
                    state_next = st_calc;
                end
            end
            st_calc_last: begin
                // Either start the next strip or finish the image.
                if (go) begin
                    state_next = strip.last_strip ? st_done : st_load_1;
                end
            end
            st_load_last: begin
                if (go) begin
                    state_next = st_calc_last;
                end
            end
            st_done: begin
                // Done is held until the host releases go.
                if (!go) begin
                    state_next = st_wait;
                end
            end
            st_error: begin
                state_next = st_error;
            end
            default: begin
                // Any encoding outside the list is a fault and is kept visible.
                state_next = st_error;
            end
        endcase
    end

    // The row registers shift on every load state and hold otherwise.
    always_comb begin
        case (state)
            st_load_1, st_load_2, st_load_3, st_load_next, st_load_last: begin
                row_op = row_op_shift_row;
            end
            default: begin
                row_op = row_op_hold;
            end
        endcase
    end

    // Strobes for the counter and the address generator.
    // Load_3 and the two load states differ only in their strobes.
    always_comb begin
        step             = '0;
        step.start       = (state == st_wait) && go;
        step.idle        = (state == st_wait);
        step.first_load  = (state == st_load_1);
        step.hold_read   = (state == st_load_2);
        step.row_advance = (state == st_load_next) || (state == st_load_last);
        step.strip_start = (state == st_load_last);
        step.out_row     = (state == st_calc);
        step.strip_end   = (state == st_calc_last);
        step.clear       = (state == st_done) || (state == st_error);
    end

    // Status reports the raw state plus the two host flags.
    always_comb begin
        status.state = state;
        status.error = (state == st_error);
        status.done  = (state == st_done);
    end

endmodule

`default_nettype wire

// File: sobel_ctl_pkg.sv
//////////////////////////////////////////////////
// Shared widths, state and row-command encodings and the packed
// structs that travel between the Sobel control blocks.
//////////////////////////////////////////////////
`default_nettype none

package sobel_ctl_pkg;

    // Width of a row or column count.
    localparam int DIM_WIDTH  = 10;
    // Width of a pixel offset into the input or output buffer.
    localparam int ADDR_WIDTH = 32;

    // Controller states. All ones is kept for the sticky error state.
    typedef enum logic [3:0] {
        st_wait      = 4'h0,
        st_load_1    = 4'h1,
        st_load_2    = 4'h2,
        st_load_3    = 4'h3,
        st_calc      = 4'h4,
        st_load_next = 4'h5,
        st_calc_last = 4'h6,
        st_load_last = 4'h7,
        st_done      = 4'h8,
        st_error     = 4'hf
    } ctl_state_e;

    // Command to the Sobel row registers.
    typedef enum logic {
        row_op_hold      = 1'b0,
        row_op_shift_row = 1'b1
    } row_op_e;

    // One-bit strobes decoded from the state, consumed by the counter
    // and address blocks. Start rides on idle and strip_start on row_advance.
    typedef struct packed {
        logic start;
        logic first_load;
        logic hold_read;
        logic row_advance;
        logic strip_start;
        logic out_row;
        logic strip_end;
        logic idle;
        logic clear;
    } ctl_step_t;

    // Image size in pixels, as given by the host.
    typedef struct packed {
        logic [DIM_WIDTH-1:0] n_rows;
        logic [DIM_WIDTH-1:0] n_cols;
    } image_dim_t;

    // Position of the current column strip and the two end flags.
    typedef struct packed {
        logic [DIM_WIDTH-1:0] col_strip;
        logic [DIM_WIDTH-1:0] next_strip;
        logic                 last_row;
        logic                 last_strip;
    } strip_info_t;

    // Status word seen by the host.
    typedef struct packed {
        ctl_state_e state;
        logic       error;
        logic       done;
    } ctl_status_t;

endpackage

`default_nettype wire
